// File: io_pkg.sv
/* Pad counts and JTAG pad indices, register map,
   Wishbone and TAP state enums, TAP instructions and IDCODE */
package io_pkg;

  localparam int NumMio = 16;
  localparam int NumDio = 4;
  localparam int NumIos = NumMio + NumDio; // MIO in 15:0, DIO in 19:16

  // Dedicated pads taken over in JTAG mode
  localparam int TckIdx = NumMio + 0;
  localparam int TmsIdx = NumMio + 1;
  localparam int TdiIdx = NumMio + 2;
  localparam int TdoIdx = NumMio + 3;

  // TMS doubles as an active-low chip select, so idle high
  localparam logic [NumIos-1:0] TieOffValues = NumIos'(1) << TmsIdx;

  localparam int WbAdrW = 3;

  typedef enum logic [WbAdrW-1:0] {
    REG_OUT    = 3'd0,
    REG_OE     = 3'd1,
    REG_IN     = 3'd2,
    REG_INVERT = 3'd3,
    REG_STATUS = 3'd4
  } reg_addr_e;

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

  typedef enum logic [3:0] {
    TAP_TLR, TAP_RTI,
    TAP_SEL_DR, TAP_CAP_DR, TAP_SHIFT_DR, TAP_EXIT1_DR, TAP_PAUSE_DR, TAP_EXIT2_DR, TAP_UPD_DR,
    TAP_SEL_IR, TAP_CAP_IR, TAP_SHIFT_IR, TAP_EXIT1_IR, TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPD_IR
  } tap_state_e;

  typedef enum logic [1:0] {
    IDCODE = 2'b01,
    BYPASS = 2'b11
  } tap_instr_e;

  localparam logic [31:0] IdcodeValue = 32'h0A5C1001; // LSB fixed at 1

endpackage

// File: pad_ring.sv
/* Pad ring model with output polarity inversion
   and two-flop synchronizers on pad inputs and strap */
`timescale 1ns/1ps

module pad_ring (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [io_pkg::NumIos-1:0] pad_in_i,
  input  logic                      jtag_strap_i,
  input  logic [io_pkg::NumIos-1:0] core_out_i,
  input  logic [io_pkg::NumIos-1:0] core_oe_i,
  input  logic [io_pkg::NumIos-1:0] invert_i,
  output logic [io_pkg::NumIos-1:0] pad_out_o,
  output logic [io_pkg::NumIos-1:0] pad_oe_o,
  output logic [io_pkg::NumIos-1:0] ring_in_o,
  output logic                      strap_o
);

  logic [io_pkg::NumIos-1:0] in_meta_q;
  logic [io_pkg::NumIos-1:0] in_sync_q;
  logic                      strap_meta_q;
  logic                      strap_sync_q;

  // Outgoing side
  assign pad_out_o = core_out_i ^ invert_i;
  assign pad_oe_o  = core_oe_i; // Enables never inverted

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q    <= '0;
      in_sync_q    <= '0;
      strap_meta_q <= 1'b0;
      strap_sync_q <= 1'b0;
    end else begin
      in_meta_q    <= pad_in_i;
      in_sync_q    <= in_meta_q;
      strap_meta_q <= jtag_strap_i;
      strap_sync_q <= strap_meta_q;
    end
  end

  assign ring_in_o = in_sync_q ^ invert_i; // Polarity after the synchronizer
  assign strap_o   = strap_sync_q;

endmodule

// File: jtag_overlay_mux.sv
/* JTAG overlay on the dedicated pads with core-side tie-offs */
`timescale 1ns/1ps

module jtag_overlay_mux (
  input  logic                      strap_i,
  input  logic [io_pkg::NumIos-1:0] out_core_i,
  input  logic [io_pkg::NumIos-1:0] oe_core_i,
  input  logic [io_pkg::NumIos-1:0] in_ring_i,
  input  logic                      jtag_tdo_i,
  output logic                      jtag_active_o,
  output logic [io_pkg::NumIos-1:0] out_ring_o,
  output logic [io_pkg::NumIos-1:0] oe_ring_o,
  output logic [io_pkg::NumIos-1:0] in_core_o,
  output logic                      jtag_tck_o,
  output logic                      jtag_tms_o,
  output logic                      jtag_tdi_o
);

  assign jtag_active_o = strap_i; // Strap already synchronized in the ring

  always_comb begin
    // Normal mode defaults, TAP sees an idle bus
    out_ring_o = out_core_i;
    oe_ring_o  = oe_core_i;
    in_core_o  = in_ring_i;
    jtag_tck_o = 1'b0;
    jtag_tms_o = 1'b1;
    jtag_tdi_o = 1'b0;

    if (strap_i) begin
      jtag_tck_o = in_ring_i[io_pkg::TckIdx];
      jtag_tms_o = in_ring_i[io_pkg::TmsIdx];
      jtag_tdi_o = in_ring_i[io_pkg::TdiIdx];

      out_ring_o[io_pkg::TdoIdx] = jtag_tdo_i;
      oe_ring_o[io_pkg::TdoIdx]  = 1'b1;
      oe_ring_o[io_pkg::TckIdx]  = 1'b0; // Inputs only while JTAG owns them
      oe_ring_o[io_pkg::TmsIdx]  = 1'b0;
      oe_ring_o[io_pkg::TdiIdx]  = 1'b0;

      // Core sees fixed values on the borrowed pads
      in_core_o[io_pkg::TckIdx] = io_pkg::TieOffValues[io_pkg::TckIdx];
      in_core_o[io_pkg::TmsIdx] = io_pkg::TieOffValues[io_pkg::TmsIdx];
      in_core_o[io_pkg::TdiIdx] = io_pkg::TieOffValues[io_pkg::TdiIdx];
      in_core_o[io_pkg::TdoIdx] = io_pkg::TieOffValues[io_pkg::TdoIdx];
    end
  end

endmodule

// File: pinctrl_regs.sv
/* Wishbone classic pin controller with output, enable and
   invert registers plus input and status readback */
`timescale 1ns/1ps

module pinctrl_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [io_pkg::WbAdrW-1:0] wb_adr_i,
  input  logic [31:0]               wb_dat_i,
  input  logic [io_pkg::NumIos-1:0] core_in_i,
  input  logic                      jtag_active_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  output logic [io_pkg::NumIos-1:0] core_out_o,
  output logic [io_pkg::NumIos-1:0] core_oe_o,
  output logic [io_pkg::NumIos-1:0] invert_o
);

  io_pkg::wb_state_e         state_q;
  logic                      req;
  logic [io_pkg::NumIos-1:0] out_q;
  logic [io_pkg::NumIos-1:0] oe_q;
  logic [io_pkg::NumIos-1:0] inv_q;
  logic [31:0]               rdata_d;
  logic [31:0]               rdata_q;

  assign req = wb_cyc_i & wb_stb_i;

  // Handshake FSM, ack one cycle after the request is seen
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= io_pkg::WB_IDLE;
    end else begin
      case (state_q)
        io_pkg::WB_IDLE: if (req) state_q <= io_pkg::WB_ACK;
        default:         state_q <= io_pkg::WB_IDLE; // Master drops stb after ack
      endcase
    end
  end

  assign wb_ack_o = (state_q == io_pkg::WB_ACK);

  ////////////////////////////////////////
  // Register file

  // Writes land at the end of the ack cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
      inv_q <= '0;
    end else if (wb_ack_o && req && wb_we_i) begin
      case (io_pkg::reg_addr_e'(wb_adr_i))
        io_pkg::REG_OUT:    out_q <= wb_dat_i[io_pkg::NumIos-1:0];
        io_pkg::REG_OE:     oe_q  <= wb_dat_i[io_pkg::NumIos-1:0];
        io_pkg::REG_INVERT: inv_q <= wb_dat_i[io_pkg::NumIos-1:0];
        default: ; // Read-only and unmapped writes dropped
      endcase
    end
  end

  always_comb begin
    case (io_pkg::reg_addr_e'(wb_adr_i))
      io_pkg::REG_OUT:    rdata_d = 32'(out_q);
      io_pkg::REG_OE:     rdata_d = 32'(oe_q);
      io_pkg::REG_IN:     rdata_d = 32'(core_in_i);
      io_pkg::REG_INVERT: rdata_d = 32'(inv_q);
      io_pkg::REG_STATUS: rdata_d = 32'(jtag_active_i);
      default:            rdata_d = '0;
    endcase
  end

  // Read data sampled with the request so it is valid alongside ack
  always_ff @(posedge clk_i) begin
    if (state_q == io_pkg::WB_IDLE && req) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_dat_o   = rdata_q;
  assign core_out_o = out_q;
  assign core_oe_o  = oe_q;
  assign invert_o   = inv_q;

endmodule

// File: jtag_tap.sv
/* Oversampled JTAG TAP controller with IDCODE and BYPASS */
`timescale 1ns/1ps

module jtag_tap (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic jtag_active_i,
  input  logic tck_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o
);

  logic [2:0]           jtag_meta_q; // {tdi, tms, tck}
  logic [2:0]           jtag_sync_q;
  logic                 tck_prev_q;
  logic                 tck_rise;
  logic                 tck_fall;
  logic                 tms;
  logic                 tdi;
  io_pkg::tap_state_e   state_q;
  io_pkg::tap_state_e   state_d;
  io_pkg::tap_instr_e   ir_q;
  logic [1:0]           ir_sr_q;
  logic [31:0]          idcode_sr_q;
  logic                 bypass_q;
  logic                 tdo_q;

  ////////////////////////////////////////
  // TCK oversampling

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      jtag_meta_q <= 3'b010;
      jtag_sync_q <= 3'b010;
      tck_prev_q  <= 1'b0;
    end else begin
      jtag_meta_q <= {tdi_i, tms_i, tck_i};
      jtag_sync_q <= jtag_meta_q;
      tck_prev_q  <= jtag_sync_q[0];
    end
  end

  assign tck_rise = jtag_sync_q[0] & ~tck_prev_q;
  assign tck_fall = ~jtag_sync_q[0] & tck_prev_q;
  assign tms      = jtag_sync_q[1];
  assign tdi      = jtag_sync_q[2];

  ////////////////////////////////////////
  // TAP state machine

  always_comb begin
    case (state_q)
      io_pkg::TAP_TLR:      state_d = tms ? io_pkg::TAP_TLR      : io_pkg::TAP_RTI;
      io_pkg::TAP_RTI:      state_d = tms ? io_pkg::TAP_SEL_DR   : io_pkg::TAP_RTI;
      io_pkg::TAP_SEL_DR:   state_d = tms ? io_pkg::TAP_SEL_IR   : io_pkg::TAP_CAP_DR;
      io_pkg::TAP_CAP_DR:   state_d = tms ? io_pkg::TAP_EXIT1_DR : io_pkg::TAP_SHIFT_DR;
      io_pkg::TAP_SHIFT_DR: state_d = tms ? io_pkg::TAP_EXIT1_DR : io_pkg::TAP_SHIFT_DR;
      io_pkg::TAP_EXIT1_DR: state_d = tms ? io_pkg::TAP_UPD_DR   : io_pkg::TAP_PAUSE_DR;
      io_pkg::TAP_PAUSE_DR: state_d = tms ? io_pkg::TAP_EXIT2_DR : io_pkg::TAP_PAUSE_DR;
      io_pkg::TAP_EXIT2_DR: state_d = tms ? io_pkg::TAP_UPD_DR   : io_pkg::TAP_SHIFT_DR;
      io_pkg::TAP_UPD_DR:   state_d = tms ? io_pkg::TAP_SEL_DR   : io_pkg::TAP_RTI;
      io_pkg::TAP_SEL_IR:   state_d = tms ? io_pkg::TAP_TLR      : io_pkg::TAP_CAP_IR;
      io_pkg::TAP_CAP_IR:   state_d = tms ? io_pkg::TAP_EXIT1_IR : io_pkg::TAP_SHIFT_IR;
      io_pkg::TAP_SHIFT_IR: state_d = tms ? io_pkg::TAP_EXIT1_IR : io_pkg::TAP_SHIFT_IR;
      io_pkg::TAP_EXIT1_IR: state_d = tms ? io_pkg::TAP_UPD_IR   : io_pkg::TAP_PAUSE_IR;
      io_pkg::TAP_PAUSE_IR: state_d = tms ? io_pkg::TAP_EXIT2_IR : io_pkg::TAP_PAUSE_IR;
      io_pkg::TAP_EXIT2_IR: state_d = tms ? io_pkg::TAP_UPD_IR   : io_pkg::TAP_SHIFT_IR;
      default:              state_d = tms ? io_pkg::TAP_SEL_DR   : io_pkg::TAP_RTI;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= io_pkg::TAP_TLR;
      ir_q    <= io_pkg::IDCODE;
      tdo_q   <= 1'b0;
    end else if (!jtag_active_i) begin
      state_q <= io_pkg::TAP_TLR; // Parked while pads are GPIO
      ir_q    <= io_pkg::IDCODE;
      tdo_q   <= 1'b0;
    end else begin
      if (tck_rise) begin
        state_q <= state_d;
        if (state_q == io_pkg::TAP_TLR) begin
          ir_q <= io_pkg::IDCODE;
        end else if (state_q == io_pkg::TAP_UPD_IR) begin
          // Unused codes fall back to BYPASS
          ir_q <= (ir_sr_q == io_pkg::IDCODE) ? io_pkg::IDCODE : io_pkg::BYPASS;
        end
      end
      if (tck_fall) begin
        case (state_q)
          io_pkg::TAP_SHIFT_IR: tdo_q <= ir_sr_q[0];
          io_pkg::TAP_SHIFT_DR: tdo_q <= (ir_q == io_pkg::IDCODE) ? idcode_sr_q[0] : bypass_q;
          default:              tdo_q <= 1'b0;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Instruction and data shift registers

  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        io_pkg::TAP_CAP_IR:   ir_sr_q <= 2'b01; // Fixed capture pattern
        io_pkg::TAP_SHIFT_IR: ir_sr_q <= {tdi, ir_sr_q[1]};
        io_pkg::TAP_CAP_DR: begin
          idcode_sr_q <= io_pkg::IdcodeValue;
          bypass_q    <= 1'b0;
        end
        io_pkg::TAP_SHIFT_DR: begin
          if (ir_q == io_pkg::IDCODE) begin
            idcode_sr_q <= {tdi, idcode_sr_q[31:1]}; // LSB out first
          end else begin
            bypass_q <= tdi;
          end
        end
        default: ;
      endcase
    end
  end

  assign tdo_o = tdo_q;

endmodule

// File: chip_io_top.sv
/* Pin subsystem top: pad ring, JTAG overlay mux,
   Wishbone pin controller and debug TAP */
`timescale 1ns/1ps

module chip_io_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Wishbone classic slave
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [io_pkg::WbAdrW-1:0] wb_adr_i,
  input  logic [31:0]               wb_dat_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  // Pads
  input  logic [io_pkg::NumIos-1:0] pad_in_i,
  output logic [io_pkg::NumIos-1:0] pad_out_o,
  output logic [io_pkg::NumIos-1:0] pad_oe_o,
  input  logic                      jtag_strap_i
);

  logic [io_pkg::NumIos-1:0] ring_out, ring_oe, ring_in;
  logic [io_pkg::NumIos-1:0] core_out, core_oe, core_in;
  logic [io_pkg::NumIos-1:0] invert;
  logic                      strap_sync, jtag_active;
  logic                      jtag_tck, jtag_tms, jtag_tdi, jtag_tdo;

  ////////////////////////////////////////
  // Pad ring

  pad_ring u_pad_ring (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .pad_in_i     ( pad_in_i     ),
    .jtag_strap_i ( jtag_strap_i ),
    .core_out_i   ( ring_out     ),
    .core_oe_i    ( ring_oe      ),
    .invert_i     ( invert       ),
    .pad_out_o    ( pad_out_o    ),
    .pad_oe_o     ( pad_oe_o     ),
    .ring_in_o    ( ring_in      ),
    .strap_o      ( strap_sync   )
  );

  ////////////////////////////////////////
  // JTAG overlay

  jtag_overlay_mux u_jtag_mux (
    .strap_i       ( strap_sync  ),
    .out_core_i    ( core_out    ),
    .oe_core_i     ( core_oe     ),
    .in_ring_i     ( ring_in     ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .jtag_active_o ( jtag_active ),
    .out_ring_o    ( ring_out    ),
    .oe_ring_o     ( ring_oe     ),
    .in_core_o     ( core_in     ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    )
  );

  ////////////////////////////////////////
  // Core side

  pinctrl_regs u_pinctrl (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .wb_cyc_i      ( wb_cyc_i    ),
    .wb_stb_i      ( wb_stb_i    ),
    .wb_we_i       ( wb_we_i     ),
    .wb_adr_i      ( wb_adr_i    ),
    .wb_dat_i      ( wb_dat_i    ),
    .core_in_i     ( core_in     ),
    .jtag_active_i ( jtag_active ),
    .wb_dat_o      ( wb_dat_o    ),
    .wb_ack_o      ( wb_ack_o    ),
    .core_out_o    ( core_out    ),
    .core_oe_o     ( core_oe     ),
    .invert_o      ( invert      )
  );

  jtag_tap u_tap (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .jtag_active_i ( jtag_active ),
    .tck_i         ( jtag_tck    ),
    .tms_i         ( jtag_tms    ),
    .tdi_i         ( jtag_tdi    ),
    .tdo_o         ( jtag_tdo    )
  );

endmodule

// File: chip_io_sva.sv
/* Concurrent checks on the Wishbone handshake,
   pad output rules and JTAG tie-offs */
`timescale 1ns/1ps

module chip_io_sva (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      wb_cyc_i,
  input logic                      wb_stb_i,
  input logic                      wb_ack_i,
  input logic                      jtag_active_i,
  input logic [io_pkg::NumIos-1:0] core_out_i,
  input logic [io_pkg::NumIos-1:0] core_oe_i,
  input logic [io_pkg::NumIos-1:0] invert_i,
  input logic [io_pkg::NumIos-1:0] core_in_i,
  input logic [io_pkg::NumIos-1:0] pad_out_i,
  input logic [io_pkg::NumIos-1:0] pad_oe_i
);

  ////////////////////////////////////////
  // Wishbone handshake

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack_o held high for more than one cycle");

  ack_has_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o raised without a preceding request");

  ////////////////////////////////////////
  // Pad side

  gpio_pads: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !jtag_active_i |-> (pad_out_i == (core_out_i ^ invert_i)) && (pad_oe_i == core_oe_i))
    else $error("GPIO pads do not follow the output, enable and invert registers");

  // TMS reads back high like an idle chip select
  jtag_tie_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_active_i |-> core_in_i[io_pkg::TmsIdx] && !core_in_i[io_pkg::TckIdx]
                      && !core_in_i[io_pkg::TdiIdx] && !core_in_i[io_pkg::TdoIdx])
    else $error("Core input on JTAG pads differs from the tie-off values");

  jtag_pad_oe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_active_i |-> pad_oe_i[io_pkg::TdoIdx]
                      && (pad_oe_i[io_pkg::TdiIdx:io_pkg::TckIdx] == 3'b000))
    else $error("JTAG pad output enables wrong while JTAG is active");

endmodule

// File: tb_clock.sv
/* Testbench clock, 8 ns period, and power-on reset */
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o); // Reset held for 8 cycles
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: tb_chip_io.sv
/* Testbench top for the pin subsystem: Wishbone and
   JTAG bus tasks, stimulus and the closing report */
`timescale 1ns/1ps

module tb_chip_io;

  localparam int          AckTimeout = 16;
  localparam int          TckTimeout = 32;
  localparam int          RstTimeout = 20;
  localparam logic [31:0] RegMask    = (32'h1 << io_pkg::NumIos) - 32'h1;
  localparam logic [31:0] ExpIdcode  = 32'h0A5C1001;

  logic                      clk;
  logic                      rst_n;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [io_pkg::WbAdrW-1:0] wb_adr;
  logic [31:0]               wb_wdat;
  logic [31:0]               wb_rdat;
  logic                      wb_ack;
  logic [io_pkg::NumIos-1:0] pad_in;
  logic [io_pkg::NumIos-1:0] pad_out;
  logic [io_pkg::NumIos-1:0] pad_oe;
  logic                      strap;

  int unsigned value_errors;
  int unsigned timeout_errors;
  logic [31:0] out_s;   // Expected REG_OUT
  logic [31:0] oe_s;    // Expected REG_OE
  logic [31:0] inv_s;   // Expected REG_INVERT
  logic [31:0] wdat;
  logic [31:0] pattern;
  logic [31:0] idcode;
  logic [15:0] tdi_bits;
  logic [15:0] tdo_bits;
  logic        tdo;

  tb_clock clock0 (.clk_o(clk), .rst_n_o(rst_n));

  chip_io_top dut0 (
    .clk_i(clk), .rst_n_i(rst_n),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
    .pad_in_i(pad_in), .pad_out_o(pad_out), .pad_oe_o(pad_oe), .jtag_strap_i(strap)
  );

  bind chip_io_top chip_io_sva sva0 (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_ack_i(wb_ack_o), .jtag_active_i(jtag_active), .core_out_i(core_out),
    .core_oe_i(core_oe), .invert_i(invert), .core_in_i(core_in),
    .pad_out_i(pad_out_o), .pad_oe_i(pad_oe_o)
  );

  task automatic next_cycle();
    @(posedge clk);
    #1; // Drive just after the edge
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("CHECK FAILED %s: expected 0x%08h, got 0x%08h", name, exp, got);
    end
  endtask

  ////////////////////////////////////////
  // Wishbone master

  task automatic wb_access(input logic we, input logic [io_pkg::WbAdrW-1:0] adr,
                           input logic [31:0] dat, output logic [31:0] rdat);
    int waited;
    waited  = 0;
    rdat    = '0;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = dat;
    do begin
      next_cycle();
      waited++;
    end while (!wb_ack && waited < AckTimeout);
    if (!wb_ack) begin
      timeout_errors++;
      $display("Timeout: no Wishbone ack for address %0d", adr);
    end else begin
      rdat = wb_rdat;
    end
    next_cycle(); // Write lands on this edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input logic [io_pkg::WbAdrW-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic read_check(input logic [io_pkg::WbAdrW-1:0] adr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rdat;
    wb_access(1'b0, adr, '0, rdat);
    check_value(name, rdat, exp);
  endtask

  task automatic check_pads();
    check_value("pad_out_o", 32'(pad_out), out_s ^ inv_s);
    check_value("pad_oe_o", 32'(pad_oe), oe_s);
  endtask

  ////////////////////////////////////////
  // JTAG host on the dedicated pads

  // Waits until the TAP edge detector has taken the new TCK level
  task automatic wait_tck_seen(input logic level);
    int waited;
    waited = 0;
    while (dut0.u_tap.tck_prev_q !== level && waited < TckTimeout) begin
      next_cycle();
      waited++;
    end
    if (dut0.u_tap.tck_prev_q !== level) begin
      timeout_errors++;
      $display("Timeout: TAP never saw TCK at level %0b", level);
    end
  endtask

  task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo_seen);
    pad_in[io_pkg::TckIdx] = 1'b0;
    pad_in[io_pkg::TmsIdx] = tms;
    pad_in[io_pkg::TdiIdx] = tdi;
    wait_tck_seen(1'b0);
    tdo_seen = pad_out[io_pkg::TdoIdx]; // TDO settled after the falling edge
    pad_in[io_pkg::TckIdx] = 1'b1;
    wait_tck_seen(1'b1);
  endtask

  task automatic tms_walk(input logic [7:0] tms_seq, input int count);
    logic unused;
    for (int i = 0; i < count; i++) begin
      tck_cycle(tms_seq[i], 1'b0, unused); // LSB first
    end
  endtask

  ////////////////////////////////////////
  // Stimulus

  initial begin
    void'($urandom(20148));
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdat = '0;
    pad_in = '0;
    strap = 1'b0;
    value_errors = 0;
    timeout_errors = 0;
    for (int i = 0; i < RstTimeout && !rst_n; i++) @(posedge clk);
    if (!rst_n) begin
      timeout_errors++;
      $display("Timeout: reset was never released");
    end
    next_cycle();

    // Reset values
    check_value("wb_ack_o", 32'(wb_ack), 32'h0);
    check_value("pad_oe_o", 32'(pad_oe), 32'h0);
    check_value("pad_out_o", 32'(pad_out), 32'h0);
    read_check(io_pkg::REG_OUT, 32'h0, "REG_OUT");
    read_check(io_pkg::REG_OE, 32'h0, "REG_OE");
    read_check(io_pkg::REG_INVERT, 32'h0, "REG_INVERT");
    out_s = '0;
    oe_s = '0;
    inv_s = '0;

    // Random register writes, pads follow one clock after ack
    for (int i = 0; i < 6; i++) begin
      wdat = $urandom();
      write_reg(io_pkg::REG_OUT, wdat);
      out_s = wdat & RegMask;
      check_pads();
      wdat = $urandom();
      write_reg(io_pkg::REG_OE, wdat);
      oe_s = wdat & RegMask;
      check_pads();
      wdat = $urandom();
      write_reg(io_pkg::REG_INVERT, wdat);
      inv_s = wdat & RegMask;
      check_pads();
      read_check(io_pkg::REG_OUT, out_s, "REG_OUT");
      read_check(io_pkg::REG_OE, oe_s, "REG_OE");
      read_check(io_pkg::REG_INVERT, inv_s, "REG_INVERT");
    end

    // Input readback and writes that must be ignored
    pattern = $urandom() & RegMask;
    pad_in = pattern[io_pkg::NumIos-1:0];
    repeat (3) next_cycle();
    read_check(io_pkg::REG_IN, pattern ^ inv_s, "REG_IN");
    write_reg(io_pkg::REG_IN, ~pattern);
    for (int a = 5; a < 8; a++) begin
      write_reg(3'(a), $urandom());
      read_check(3'(a), 32'h0, "unmapped read");
    end
    read_check(io_pkg::REG_IN, pattern ^ inv_s, "REG_IN");
    read_check(io_pkg::REG_OUT, out_s, "REG_OUT");
    read_check(io_pkg::REG_OE, oe_s, "REG_OE");
    read_check(io_pkg::REG_INVERT, inv_s, "REG_INVERT");
    check_pads();

    // Strap on, core sees tie-offs on the JTAG pads only
    strap = 1'b1;
    repeat (3) next_cycle();
    read_check(io_pkg::REG_STATUS, 32'h1, "REG_STATUS");
    read_check(io_pkg::REG_IN, ((pattern ^ inv_s) & 32'h0000_FFFF) | (32'h1 << io_pkg::TmsIdx),
               "REG_IN");

    // IDCODE read, TCK low and TMS high to start
    pad_in[io_pkg::TdoIdx:io_pkg::TckIdx] = 4'b0010;
    write_reg(io_pkg::REG_INVERT, 32'h0);
    inv_s = '0;
    repeat (8) next_cycle();
    tms_walk(8'b0001_1111, 6); // Test-Logic-Reset then Run-Test/Idle
    tms_walk(8'b0000_0001, 3); // To Shift-DR
    for (int i = 0; i < 32; i++) begin
      tck_cycle(i == 31, 1'b0, tdo);
      idcode[i] = tdo;
    end
    check_value("IDCODE on pad_out_o[19]", idcode, ExpIdcode);
    tms_walk(8'b0000_0001, 2); // Update-DR, Run-Test/Idle

    // Load BYPASS
    tms_walk(8'b0000_0011, 4);
    tck_cycle(1'b0, 1'b1, tdo);
    tck_cycle(1'b1, 1'b1, tdo);
    tms_walk(8'b0000_0001, 2);

    // Bypass stream comes back one TCK late
    tdi_bits = 16'($urandom());
    tms_walk(8'b0000_0001, 3);
    for (int i = 0; i < 16; i++) begin
      tck_cycle(i == 15, tdi_bits[i], tdo);
      tdo_bits[i] = tdo;
    end
    check_value("bypass on pad_out_o[19]", 32'(tdo_bits), 32'({tdi_bits[14:0], 1'b0}));
    tms_walk(8'b0000_0001, 2);

    // Back to GPIO on all pads
    strap = 1'b0;
    repeat (3) next_cycle();
    read_check(io_pkg::REG_STATUS, 32'h0, "REG_STATUS");
    wdat = $urandom();
    write_reg(io_pkg::REG_OUT, wdat);
    out_s = wdat & RegMask;
    wdat = $urandom();
    write_reg(io_pkg::REG_OE, wdat);
    oe_s = wdat & RegMask;
    check_pads();
    pattern = $urandom() & RegMask;
    pad_in = pattern[io_pkg::NumIos-1:0];
    repeat (3) next_cycle();
    read_check(io_pkg::REG_IN, pattern, "REG_IN");

    $display("Error counts: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: compile.f
io_pkg.sv
pad_ring.sv
jtag_overlay_mux.sv
pinctrl_regs.sv
jtag_tap.sv
chip_io_top.sv
chip_io_sva.sv
tb_clock.sv
tb_chip_io.sv

// File: Makefile
# Verilator build and run for the pin subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_chip_io
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
